//--- hdl/mapManPkg.sv
package mapManPkg;

	////////////////////
	// Sizes
	////////////////////

	parameter int tableDepth = 8;           // Default number of table entries
	parameter int idWidth = 4;
	parameter int addressWidth = 10;        // Address and length in program words
	parameter int memSize = 1000;           // Default program memory size in words

	////////////////////
	// Types
	////////////////////

	// One table entry, 25 bits
	typedef struct packed {
		logic valid;
		logic [idWidth-1:0] threadId;
		logic [addressWidth-1:0] address;
		logic [addressWidth-1:0] length;
	} mapEntry;

	// Four-phase port states
	// respond is the first ack cycle, waitDrop holds ack until req falls
	typedef enum logic [1:0] {
		idle,
		respond,
		waitDrop
	} fsmState;

endpackage

//--- hdl/mapManIfs.sv
`timescale 1ns/1ps

// Table control and lookup results between the FSM and the entry table
interface tableBus import mapManPkg::*; ();
	logic write;                            // Store a new entry
	logic releaseEntry;                     // Invalidate the matched lookup entry
	logic [idWidth-1:0] writeId;
	logic [addressWidth-1:0] writeLength;
	logic [addressWidth-1:0] writeAddress;
	logic [idWidth-1:0] lookupId;
	logic freeFound;                        // At least one invalid entry
	logic idPresent;                        // writeId already live
	logic hit;
	logic [addressWidth-1:0] hitAddress;
	logic [addressWidth-1:0] hitLength;

	modport fsm (
		output write, releaseEntry, writeId, writeLength, writeAddress, lookupId,
		input freeFound, idPresent, hit, hitAddress, hitLength
	);

	modport tableSide (
		input write, releaseEntry, writeId, writeLength, writeAddress, lookupId,
		output freeFound, idPresent, hit, hitAddress, hitLength
	);
endinterface

// Allocation and free requests between the FSM and the space counters
interface spaceBus import mapManPkg::*; ();
	logic allocate;
	logic [addressWidth-1:0] allocLength;
	logic free;
	logic [addressWidth-1:0] freeLength;
	logic [addressWidth-1:0] nextAddress;   // Bump pointer
	logic empty;                            // No live programs

	modport fsm (output allocate, allocLength, free, freeLength, input nextAddress, empty);

	modport counter (input allocate, allocLength, free, freeLength, output nextAddress, empty);
endinterface

//--- hdl/handshakeFsm.sv
`timescale 1ns/1ps

module handshakeFsm import mapManPkg::*; #(
	parameter int memSize = mapManPkg::memSize
) (
	input logic clock,
	input logic reset,
	input logic storeReq,
	input logic [addressWidth-1:0] storeLength,
	input logic [idWidth-1:0] storeId,
	output logic storeAck,
	output logic storeGrant,
	input logic lookupReq,
	input logic [idWidth-1:0] lookupId,
	output logic lookupAck,
	output logic lookupHit,
	output logic [addressWidth-1:0] lookupAddress,
	output logic [addressWidth-1:0] lookupLength,
	tableBus.fsm tb,
	spaceBus.fsm sb
);

	fsmState storeState;
	fsmState lookupState;
	logic storeStart;
	logic lookupStart;
	logic storeCommit;
	logic lookupCommit;
	logic [addressWidth-1:0] baseAddress;
	logic [addressWidth:0] storeEnd;        // One bit wider to catch the carry
	logic grantNow;

	// Same four-phase sequence for both ports
	function automatic fsmState nextState(input fsmState state, input logic req);
		case (state)
			idle: return req ? respond : idle;
			respond: return req ? waitDrop : idle;
			default: return req ? waitDrop : idle;
		endcase
	endfunction

	////////////////////
	// Decisions
	////////////////////

	assign storeStart = (storeState == idle) && storeReq;
	assign lookupStart = (lookupState == idle) && lookupReq;

	assign baseAddress = sb.empty ? '0 : sb.nextAddress;  // Empty map restarts at zero
	assign storeEnd = {1'b0, baseAddress} + {1'b0, storeLength};

	// Free slot, new ID and room left in program memory
	assign grantNow = tb.freeFound && !tb.idPresent && (int'(storeEnd) <= memSize);

	assign storeCommit = storeStart && grantNow;
	assign lookupCommit = lookupStart && tb.hit;

	assign tb.write = storeCommit;
	assign tb.writeId = storeId;
	assign tb.writeLength = storeLength;
	assign tb.writeAddress = baseAddress;
	assign tb.lookupId = lookupId;
	assign tb.releaseEntry = lookupCommit;

	assign sb.allocate = storeCommit;
	assign sb.allocLength = storeLength;
	assign sb.free = lookupCommit;
	assign sb.freeLength = tb.hitLength;

	////////////////////
	// Port state
	////////////////////

	always_ff @(posedge clock) begin
		if (reset) begin
			storeState <= idle;
			lookupState <= idle;
		end else begin
			storeState <= nextState(storeState, storeReq);
			lookupState <= nextState(lookupState, lookupReq);
		end
	end

	assign storeAck = (storeState != idle);
	assign lookupAck = (lookupState != idle);

	// Results hold until the next ack rises
	always_ff @(posedge clock) begin
		if (reset) begin
			storeGrant <= 1'b0;
			lookupHit <= 1'b0;
			lookupAddress <= '0;
			lookupLength <= '0;
		end else begin
			if (storeStart) begin
				storeGrant <= grantNow;
			end
			if (lookupStart) begin
				lookupHit <= tb.hit;
				lookupAddress <= tb.hitAddress;  // Zero on a miss
				lookupLength <= tb.hitLength;
			end
		end
	end

endmodule

//--- hdl/spaceCounter.sv
`timescale 1ns/1ps

module spaceCounter import mapManPkg::*; #(
	parameter int memSize = mapManPkg::memSize
) (
	input logic clock,
	input logic reset,
	spaceBus.counter sb,
	output logic [addressWidth-1:0] usedSize,
	output logic full
);

	logic [addressWidth-1:0] nextAddress;
	logic [addressWidth-1:0] usedCount;
	logic [addressWidth-1:0] addAmount;
	logic [addressWidth-1:0] subAmount;
	logic [idWidth:0] liveCount;            // IDs are unique so this cannot overflow
	logic lastFreed;

	assign addAmount = sb.allocate ? sb.allocLength : '0;
	assign subAmount = sb.free ? sb.freeLength : '0;

	// Last program leaves and nothing new arrives
	assign lastFreed = sb.free && !sb.allocate && (liveCount == 1);

	////////////////////
	// Counters
	////////////////////

	always_ff @(posedge clock) begin
		if (reset) begin
			nextAddress <= '0;
			usedCount <= '0;
			liveCount <= '0;
		end else begin
			if (lastFreed) begin
				nextAddress <= '0;
			end else if (sb.allocate) begin
				nextAddress <= nextAddress + sb.allocLength;
			end

			usedCount <= usedCount + addAmount - subAmount;  // Store and free in one step

			case ({sb.allocate, sb.free})
				2'b10: liveCount <= liveCount + 1;
				2'b01: liveCount <= liveCount - 1;
				default: liveCount <= liveCount;
			endcase
		end
	end

	assign sb.nextAddress = nextAddress;
	assign sb.empty = (liveCount == 0);

	assign usedSize = usedCount;
	assign full = int'(usedCount) >= (memSize - 1);

endmodule

//--- hdl/mapTable.sv
`timescale 1ns/1ps

module mapTable import mapManPkg::*; #(
	parameter int tableDepth = mapManPkg::tableDepth
) (
	input logic clock,
	input logic reset,
	tableBus.tableSide tb
);

	localparam int indexWidth = (tableDepth > 1) ? $clog2(tableDepth) : 1;

	mapEntry entries [tableDepth];
	logic [tableDepth-1:0] validBits;
	logic [tableDepth-1:0] lookupMatch;     // One-hot, IDs are unique
	logic [tableDepth-1:0] writeMatch;
	logic [indexWidth-1:0] freeIndex;
	logic [indexWidth-1:0] hitIndex;
	mapEntry newEntry;

	////////////////////
	// Match and search
	////////////////////

	always_comb begin
		for (int i = 0; i < tableDepth; i++) begin
			validBits[i] = entries[i].valid;
			lookupMatch[i] = entries[i].valid && (entries[i].threadId == tb.lookupId);
			writeMatch[i] = entries[i].valid && (entries[i].threadId == tb.writeId);
		end
	end

	// Lowest invalid entry wins, so scan downward
	always_comb begin
		freeIndex = '0;
		for (int i = tableDepth - 1; i >= 0; i--) begin
			if (!validBits[i]) begin
				freeIndex = indexWidth'(i);
			end
		end
	end

	// One-hot to binary
	always_comb begin
		hitIndex = '0;
		for (int i = 0; i < tableDepth; i++) begin
			if (lookupMatch[i]) begin
				hitIndex = hitIndex | indexWidth'(i);
			end
		end
	end

	assign tb.freeFound = ~&validBits;
	assign tb.idPresent = |writeMatch;
	assign tb.hit = |lookupMatch;

	// Miss reads back as zero
	assign tb.hitAddress = tb.hit ? entries[hitIndex].address : '0;
	assign tb.hitLength = tb.hit ? entries[hitIndex].length : '0;

	////////////////////
	// Storage
	////////////////////

	always_comb begin
		newEntry.valid = 1'b1;
		newEntry.threadId = tb.writeId;
		newEntry.address = tb.writeAddress;
		newEntry.length = tb.writeLength;
	end

	// Release hits a valid entry and write an invalid one, never the same slot
	always_ff @(posedge clock) begin
		if (reset) begin
			for (int i = 0; i < tableDepth; i++) begin
				entries[i] <= '0;
			end
		end else begin
			if (tb.releaseEntry) begin
				entries[hitIndex].valid <= 1'b0;
			end
			if (tb.write) begin
				entries[freeIndex] <= newEntry;
			end
		end
	end

endmodule

//--- hdl/mapManager.sv
`timescale 1ns/1ps

module mapManager import mapManPkg::*; #(
	parameter int tableDepth = mapManPkg::tableDepth,
	parameter int memSize = mapManPkg::memSize
) (
	input logic clock,
	input logic reset,

	// Store port
	input logic storeReq,
	input logic [idWidth-1:0] storeId,
	input logic [addressWidth-1:0] storeLength,
	output logic storeAck,
	output logic storeGrant,

	// Lookup port
	input logic lookupReq,
	input logic [idWidth-1:0] lookupId,
	output logic lookupAck,
	output logic lookupHit,
	output logic [addressWidth-1:0] lookupAddress,
	output logic [addressWidth-1:0] lookupLength,

	// Occupancy
	output logic [addressWidth-1:0] usedSize,
	output logic full
);

	tableBus tableLink ();
	spaceBus spaceLink ();

	////////////////////
	// Port control
	////////////////////

	handshakeFsm #(
		.memSize(memSize)
	) portControl (
		.clock(clock),
		.reset(reset),
		.storeReq(storeReq),
		.storeLength(storeLength),
		.storeId(storeId),
		.storeAck(storeAck),
		.storeGrant(storeGrant),
		.lookupReq(lookupReq),
		.lookupId(lookupId),
		.lookupAck(lookupAck),
		.lookupHit(lookupHit),
		.lookupAddress(lookupAddress),
		.lookupLength(lookupLength),
		.tb(tableLink.fsm),
		.sb(spaceLink.fsm)
	);

	spaceCounter #(
		.memSize(memSize)
	) space (
		.clock(clock),
		.reset(reset),
		.sb(spaceLink.counter),
		.usedSize(usedSize),
		.full(full)
	);

	mapTable #(
		.tableDepth(tableDepth)
	) entryTable (
		.clock(clock),
		.reset(reset),
		.tb(tableLink.tableSide)
	);

endmodule

//--- testbench/mapManagerTb.sv
`timescale 1ns/1ps

module mapManagerTb import mapManPkg::*; ();

	localparam int cycleLimit = 3000;

	logic clock;
	logic reset;
	logic storeReq;
	logic [idWidth-1:0] storeId;
	logic [addressWidth-1:0] storeLength;
	logic storeAck;
	logic storeGrant;
	logic lookupReq;
	logic [idWidth-1:0] lookupId;
	logic lookupAck;
	logic lookupHit;
	logic [addressWidth-1:0] lookupAddress;
	logic [addressWidth-1:0] lookupLength;
	logic [addressWidth-1:0] usedSize;
	logic full;

	// Reference model state
	mapEntry modelTable [tableDepth];
	int modelNext;
	int modelUsed;
	logic expGrant;
	logic expHit;
	int expAddress;
	int expLength;

	logic storeAckSeen;
	logic lookupAckSeen;
	logic storeRose;
	logic lookupRose;
	int unsigned lcgState = 11;
	int cycleCount = 0;
	int checkCount = 0;
	int errorCount = 0;
	int checksAtStart = 0;
	int errorsAtStart = 0;
	int testNumber = 1;

	mapManager #(
		.tableDepth(tableDepth),
		.memSize(memSize)
	) u_mapManager (
		.clock(clock),
		.reset(reset),
		.storeReq(storeReq),
		.storeId(storeId),
		.storeLength(storeLength),
		.storeAck(storeAck),
		.storeGrant(storeGrant),
		.lookupReq(lookupReq),
		.lookupId(lookupId),
		.lookupAck(lookupAck),
		.lookupHit(lookupHit),
		.lookupAddress(lookupAddress),
		.lookupLength(lookupLength),
		.usedSize(usedSize),
		.full(full)
	);

	initial begin
		clock = 1'b0;
		forever #10 clock = ~clock;
	end

	////////////////////
	// Helpers
	////////////////////

	function automatic int unsigned nextRandom();
		lcgState = lcgState * 32'd1103515245 + 32'd12345;
		return lcgState >> 16;
	endfunction

	task automatic checkValue(input string name, input int got, input int expected);
		checkCount++;
		assert (got == expected) else begin
			$display("FAILED time %0t %s got %0d expected %0d", $time, name, got, expected);
			errorCount++;
		end
	endtask

	// Both ports decide on the table as it stood before the edge
	function automatic void predict(input logic doStore, input int sId, input int sLen,
			input logic doLookup, input int lId);
		int freeSlot;
		int hitSlot;
		logic duplicate;
		logic anyLive;
		freeSlot = -1;
		hitSlot = -1;
		duplicate = 1'b0;
		anyLive = 1'b0;
		for (int i = 0; i < tableDepth; i++) begin
			if (!modelTable[i].valid && freeSlot < 0) begin
				freeSlot = i;
			end
			if (modelTable[i].valid && int'(modelTable[i].threadId) == sId) begin
				duplicate = 1'b1;
			end
			if (modelTable[i].valid && int'(modelTable[i].threadId) == lId) begin
				hitSlot = i;
			end
		end
		expGrant = doStore && (freeSlot >= 0) && !duplicate && (modelNext + sLen <= memSize);
		expHit = doLookup && (hitSlot >= 0);
		if (expHit) begin
			expAddress = int'(modelTable[hitSlot].address);
			expLength = int'(modelTable[hitSlot].length);
			modelTable[hitSlot].valid = 1'b0;
			modelUsed = modelUsed - expLength;
		end else begin
			expAddress = 0;  // Miss returns zeros
			expLength = 0;
		end
		if (expGrant) begin
			modelTable[freeSlot].valid = 1'b1;
			modelTable[freeSlot].threadId = idWidth'(sId);
			modelTable[freeSlot].address = addressWidth'(modelNext);
			modelTable[freeSlot].length = addressWidth'(sLen);
			modelNext = modelNext + sLen;
			modelUsed = modelUsed + sLen;
		end
		for (int i = 0; i < tableDepth; i++) begin
			anyLive = anyLive | modelTable[i].valid;
		end
		if (!anyLive) begin
			modelNext = 0;  // Bump pointer restarts on an empty table
		end
	endfunction

	////////////////////
	// Four-phase tasks
	////////////////////

	task automatic storeProgram(input int id, input int len);
		storeId = idWidth'(id);
		storeLength = addressWidth'(len);
		storeReq = 1'b1;
		do begin
			@(posedge clock);
			#2;
		end while (!storeAck);
		storeReq = 1'b0;
		do begin
			@(posedge clock);
			#2;
		end while (storeAck);
	endtask

	task automatic lookupThread(input int id);
		lookupId = idWidth'(id);
		lookupReq = 1'b1;
		do begin
			@(posedge clock);
			#2;
		end while (!lookupAck);
		lookupReq = 1'b0;
		do begin
			@(posedge clock);
			#2;
		end while (lookupAck);
	endtask

	// Lookup starts lag cycles after the store
	task automatic storeAndLookup(input int sId, input int sLen, input int lId, input int lag);
		fork
			storeProgram(sId, sLen);
			begin
				repeat (lag) begin
					@(posedge clock);
					#2;
				end
				lookupThread(lId);
			end
		join
	endtask

	task automatic drainTable();
		int ids[$];
		foreach (modelTable[i]) begin
			if (modelTable[i].valid) begin
				ids.push_back(int'(modelTable[i].threadId));
			end
		end
		foreach (ids[k]) begin
			lookupThread(ids[k]);
		end
	endtask

	task automatic finishTest(input string name);
		$display("test %0d %s checks %0d errors %0d", testNumber, name,
			checkCount - checksAtStart, errorCount - errorsAtStart);
		testNumber++;
		checksAtStart = checkCount;
		errorsAtStart = errorCount;
	endtask

	////////////////////
	// Compare on every rising ack
	////////////////////

	always @(negedge clock) begin
		storeRose = storeAck && !storeAckSeen;
		lookupRose = lookupAck && !lookupAckSeen;
		if (!reset && (storeRose || lookupRose)) begin
			predict(storeRose, int'(storeId), int'(storeLength), lookupRose, int'(lookupId));
			if (storeRose) begin
				checkValue("storeGrant", int'(storeGrant), int'(expGrant));
			end
			if (lookupRose) begin
				checkValue("lookupHit", int'(lookupHit), int'(expHit));
				checkValue("lookupAddress", int'(lookupAddress), expAddress);
				checkValue("lookupLength", int'(lookupLength), expLength);
			end
			checkValue("usedSize", int'(usedSize), modelUsed);
			checkValue("full", int'(full), int'(modelUsed >= memSize - 1));
		end
		storeAckSeen = storeAck;
		lookupAckSeen = lookupAck;
	end

	initial begin
		while (cycleCount < cycleLimit) begin
			@(posedge clock);
			cycleCount++;
		end
		$display("Timeout after %0d cycles, a handshake never completed", cycleLimit);
		$display("*** FAILED ***");
		$finish;
	end

	////////////////////
	// Stimulus
	////////////////////

	initial begin
		int sel;
		int id;
		int len;
		reset = 1'b1;
		storeReq = 1'b0;
		storeId = '0;
		storeLength = '0;
		lookupReq = 1'b0;
		lookupId = '0;
		storeAckSeen = 1'b0;
		lookupAckSeen = 1'b0;
		modelNext = 0;
		modelUsed = 0;
		for (int i = 0; i < tableDepth; i++) begin
			modelTable[i] = '0;
		end
		repeat (5) @(posedge clock);
		#2;
		reset = 1'b0;

		checkValue("storeAck", int'(storeAck), 0);
		checkValue("lookupAck", int'(lookupAck), 0);
		checkValue("storeGrant", int'(storeGrant), 0);
		checkValue("lookupHit", int'(lookupHit), 0);
		checkValue("usedSize", int'(usedSize), 0);
		checkValue("full", int'(full), 0);
		finishTest("reset state");

		for (int i = 1; i <= 4; i++) begin
			storeProgram(i, 10 * i);  // Addresses 0, 10, 30, 60
		end
		finishTest("sequential stores");

		lookupThread(2);
		checkValue("lookupAddress", int'(lookupAddress), 10);
		lookupThread(2);  // Entry already freed
		finishTest("lookup and release");

		storeProgram(1, 5);                     // Duplicate ID
		storeProgram(9, 950);                   // Past the end of memory
		for (int i = 5; i <= 9; i++) begin
			storeProgram(i, 20);
		end
		storeProgram(10, 5);                    // No free entry
		drainTable();
		storeProgram(0, memSize - 1);
		checkValue("full", int'(full), 1);
		storeProgram(1, 1);
		storeProgram(2, 1);
		drainTable();
		finishTest("rejections and full");

		storeProgram(3, 50);
		storeProgram(4, 60);
		storeAndLookup(5, 70, 3, 0);            // Same decision edge
		storeAndLookup(6, 80, 5, 1);            // Overlapped by one cycle
		drainTable();
		storeProgram(7, 33);
		lookupThread(7);
		checkValue("lookupAddress", int'(lookupAddress), 0);
		finishTest("concurrent ports");

		for (int n = 0; n < 200; n++) begin
			sel = int'(nextRandom() % 4);
			id = int'(nextRandom() % 16);
			len = 1 + int'(nextRandom() % 250);
			case (sel)
				0, 1: storeProgram(id, len);
				2: lookupThread(id);
				default: storeAndLookup(id, len, int'(nextRandom() % 16),
					int'(nextRandom() % 2));
			endcase
		end
		finishTest("random mix");

		$display("Total checks %0d, errors %0d", checkCount, errorCount);
		if (errorCount == 0) begin
			$display("*** PASSED ***");
		end else begin
			$display("*** FAILED ***");
		end
		$finish;
	end

endmodule

//--- mapManager.f
hdl/mapManPkg.sv
hdl/mapManIfs.sv
hdl/handshakeFsm.sv
hdl/spaceCounter.sv
hdl/mapTable.sv
hdl/mapManager.sv
testbench/mapManagerTb.sv

//--- run.sh
#!/bin/sh
# Build and run the mapManager testbench with Verilator

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
LOG_FILE=sim.log

if ! verilator --binary --timing --assert -j 0 \
	--top-module mapManagerTb -Mdir "$BUILD_DIR" -o mapManagerSim \
	-f mapManager.f; then
	echo "Verilator build failed"
	exit 1
fi

if ! "./$BUILD_DIR/mapManagerSim" > "$LOG_FILE" 2>&1; then
	cat "$LOG_FILE"
	echo "Simulation exited with an error"
	exit 1
fi

cat "$LOG_FILE"

if grep -q -F '*** PASSED ***' "$LOG_FILE"; then
	exit 0
else
	exit 1
fi
